// File: all.f
source/regex_pkg.sv
source/arbiter_fixed.sv
source/pc_queue.sv
source/basic_block.sv
source/regex_controller.sv
source/regex_coprocessor.sv
tests/regex_mem_model.sv
tests/tb_regex_coprocessor.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module tb_regex_coprocessor -o tb_sim \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

grep -q ">>> FAIL" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q ">>> PASS" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0

// File: source/arbiter_fixed.sv
module arbiter_fixed #(
    parameter type payload_t = logic
) (
    input  logic     in_0_valid,
    input  payload_t in_0_data,
    output logic     in_0_ready,
    input  logic     in_1_valid,
    input  payload_t in_1_data,
    output logic     in_1_ready,
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_ready
);

    // input 0 always wins when it asks
    assign out_valid = in_0_valid || in_1_valid;
    assign out_data  = in_0_valid ? in_0_data : in_1_data;

    // only the winner sees the downstream ready
    assign in_0_ready = out_ready && in_0_valid;
    assign in_1_ready = out_ready && !in_0_valid;

endmodule

// File: source/basic_block.sv
module basic_block #(
    parameter int MEM_ADDR_WIDTH = 11
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           flush,
    input  logic                           go,
    input  regex_pkg::char_t               cur_char,
    input  logic                           cur_parity,
    output logic                           running,
    output logic                           accepts,
    output logic                           overflow,
    input  logic                           queue_valid,
    input  regex_pkg::pc_entry_t           queue_entry,
    output logic                           queue_ready,
    output logic                           out_valid,
    output regex_pkg::pc_entry_t           out_entry,
    input  logic                           out_ready,
    output logic                           mem_valid,
    output logic [MEM_ADDR_WIDTH-1:0]      mem_addr,
    input  logic                           mem_ready,
    input  logic [regex_pkg::MEM_WIDTH-1:0] mem_data,
    input  logic                           has_current
);

    typedef enum logic [1:0] {
        BB_IDLE,
        BB_WAIT,
        BB_DATA,
        BB_EMIT
    } bb_state_t;

    bb_state_t state;
    bb_state_t state_next;

    // entry being executed and the entries it produces
    regex_pkg::pc_entry_t cur_entry;
    regex_pkg::pc_entry_t emit_first;
    regex_pkg::pc_entry_t emit_second;
    logic                 split_pending;

    regex_pkg::instr_t           instr;
    logic [regex_pkg::PC_WIDTH-1:0] pc_inc;
    logic                        pop;
    logic                        head_is_current;

    assign instr           = regex_pkg::instr_t'(mem_data);
    assign pc_inc          = cur_entry.pc + 1'b1;
    assign head_is_current = (queue_entry.parity == cur_parity);
    assign pop             = (state == BB_IDLE) && go && has_current && queue_valid;

    assign queue_ready = pop;
    assign out_valid   = (state == BB_EMIT);
    assign out_entry   = emit_first;
    assign running     = has_current || (state != BB_IDLE);
    // an entry is waiting but the queue has no room
    assign overflow    = out_valid && !out_ready;

    // a popped current entry is requested in the same cycle
    always_comb
    begin
        mem_valid  = 1'b0;
        mem_addr   = MEM_ADDR_WIDTH'(cur_entry.pc);
        state_next = state;
        case (state)
            BB_IDLE:
            begin
                if (pop && head_is_current)
                begin
                    mem_valid  = 1'b1;
                    mem_addr   = MEM_ADDR_WIDTH'(queue_entry.pc);
                    state_next = mem_ready ? BB_DATA : BB_WAIT;
                end
                else if (pop)
                begin
                    // entry of the next character goes back to the tail
                    state_next = BB_EMIT;
                end
            end
            BB_WAIT:
            begin
                mem_valid = 1'b1;
                if (mem_ready)
                begin
                    state_next = BB_DATA;
                end
            end
            BB_DATA:
            begin
                case (instr.opcode)
                    regex_pkg::CHAR:
                        state_next = (instr.operand == cur_char) ? BB_EMIT : BB_IDLE;
                    regex_pkg::ANY,
                    regex_pkg::JMP,
                    regex_pkg::SPLIT:
                        state_next = BB_EMIT;
                    default:
                        state_next = BB_IDLE;
                endcase
            end
            BB_EMIT:
            begin
                if (out_ready && !split_pending)
                begin
                    state_next = BB_IDLE;
                end
            end
            default:
                state_next = BB_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (pop)
        begin
            cur_entry  <= queue_entry;
            emit_first <= queue_entry;
        end
        else if (state == BB_DATA)
        begin
            // character consumers move on to the other parity
            if (instr.opcode == regex_pkg::CHAR || instr.opcode == regex_pkg::ANY)
            begin
                emit_first <= '{pc: pc_inc, parity: !cur_entry.parity};
            end
            else
            begin
                emit_first <= '{pc: instr.operand, parity: cur_entry.parity};
            end
            emit_second <= '{pc: pc_inc, parity: cur_entry.parity};
        end
        else if (state == BB_EMIT && out_ready && split_pending)
        begin
            emit_first <= emit_second;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset || flush)
        begin
            state         <= BB_IDLE;
            split_pending <= 1'b0;
            accepts       <= 1'b0;
        end
        else
        begin
            state <= state_next;
            if (state == BB_DATA)
            begin
                split_pending <= (instr.opcode == regex_pkg::SPLIT);
                if (instr.opcode == regex_pkg::ACCEPT)
                begin
                    accepts <= 1'b1;
                end
            end
            else if (state == BB_EMIT && out_ready)
            begin
                split_pending <= 1'b0;
            end
        end
    end

endmodule

// File: source/pc_queue.sv
module pc_queue #(
    parameter int QUEUE_DEPTH_LOG2 = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush,
    input  logic                 in_valid,
    input  regex_pkg::pc_entry_t in_entry,
    output logic                 in_ready,
    output logic                 out_valid,
    output regex_pkg::pc_entry_t out_entry,
    input  logic                 out_ready,
    input  logic                 cur_parity,
    output logic                 has_current
);

    localparam int DEPTH = 1 << QUEUE_DEPTH_LOG2;

    regex_pkg::pc_entry_t storage [DEPTH];

    logic [QUEUE_DEPTH_LOG2-1:0] wr_ptr;
    logic [QUEUE_DEPTH_LOG2-1:0] rd_ptr;

    // stored entries, one counter per parity tag
    logic [QUEUE_DEPTH_LOG2:0] count [2];
    logic [QUEUE_DEPTH_LOG2:0] total;

    logic push;
    logic pop;

    assign total       = count[0] + count[1];
    assign in_ready    = (total != (QUEUE_DEPTH_LOG2+1)'(DEPTH));
    assign out_valid   = (total != '0);
    assign out_entry   = storage[rd_ptr];
    assign has_current = (count[cur_parity] != '0);

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    // head is read straight from the array, so a push shows up a cycle later
    always_ff @(posedge clk)
    begin
        if (push)
        begin
            storage[wr_ptr] <= in_entry;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset || flush)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count[0] <= '0;
            count[1] <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // a push and a pop of the same tag cancel out
            for (int p = 0; p < 2; p++)
            begin
                count[p] <= count[p]
                    + (QUEUE_DEPTH_LOG2+1)'(push && (in_entry.parity == 1'(p)))
                    - (QUEUE_DEPTH_LOG2+1)'(pop && (out_entry.parity == 1'(p)));
            end
        end
    end

endmodule

// File: source/regex_controller.sv
module regex_controller #(
    parameter int MEM_ADDR_WIDTH = 11
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            start,
    input  logic [MEM_ADDR_WIDTH-1:0]       start_addr,
    output logic                            start_ack,
    output logic                            finish,
    output logic                            accept,
    output logic                            mem_valid,
    output logic [MEM_ADDR_WIDTH-1:0]       mem_addr,
    input  logic                            mem_ready,
    input  logic [regex_pkg::MEM_WIDTH-1:0] mem_data,
    output logic                            inject_valid,
    output regex_pkg::pc_entry_t            inject_entry,
    input  logic                            inject_ready,
    output logic                            go,
    output logic                            flush,
    output regex_pkg::char_t                cur_char,
    output logic                            cur_parity,
    input  logic                            running,
    input  logic                            accepts,
    input  logic                            overflow
);

    regex_pkg::ctrl_state_t state;
    regex_pkg::ctrl_state_t state_next;

    // byte pointer, the low bit picks the half of the word
    logic [MEM_ADDR_WIDTH:0] char_ptr;
    logic [MEM_ADDR_WIDTH:0] ptr_next;
    logic [MEM_ADDR_WIDTH:0] ptr_inc;
    regex_pkg::char_t        char_next;
    regex_pkg::char_t        sel_char;
    logic                    parity_next;

    assign ptr_inc  = char_ptr + 1'b1;
    assign sel_char = char_ptr[0]
        ? mem_data[regex_pkg::MEM_WIDTH-1 -: regex_pkg::CHAR_WIDTH]
        : mem_data[regex_pkg::CHAR_WIDTH-1:0];

    // every run starts at program counter 0
    assign inject_entry = '{pc: '0, parity: cur_parity};

    always_comb
    begin
        state_next   = state;
        ptr_next     = char_ptr;
        char_next    = cur_char;
        parity_next  = cur_parity;
        start_ack    = 1'b0;
        finish       = 1'b0;
        accept       = 1'b0;
        flush        = 1'b0;
        go           = 1'b0;
        inject_valid = 1'b0;
        mem_valid    = 1'b0;
        mem_addr     = start_addr;
        case (state)
            regex_pkg::IDLE:
            begin
                mem_valid = start;
                if (start && mem_ready)
                begin
                    start_ack  = 1'b1;
                    ptr_next   = {start_addr, 1'b0};
                    state_next = regex_pkg::FETCH_FIRST;
                end
            end
            regex_pkg::FETCH_FIRST:
            begin
                char_next    = sel_char;
                inject_valid = 1'b1;
                if (inject_ready)
                begin
                    state_next = regex_pkg::EXEC;
                end
            end
            regex_pkg::EXEC:
            begin
                go = 1'b1;
                if (accepts)
                begin
                    state_next = regex_pkg::DONE_ACCEPT;
                end
                else if (overflow)
                begin
                    state_next = regex_pkg::DONE_REJECT;
                end
                else if (!running)
                begin
                    if (cur_char == regex_pkg::CHAR_TERMINATOR)
                    begin
                        state_next = regex_pkg::DONE_REJECT;
                    end
                    else
                    begin
                        // next character, word address drops the byte bit
                        mem_valid = 1'b1;
                        mem_addr  = ptr_inc[MEM_ADDR_WIDTH:1];
                        if (mem_ready)
                        begin
                            ptr_next    = ptr_inc;
                            parity_next = !cur_parity;
                            state_next  = regex_pkg::FETCH_NEXT;
                        end
                    end
                end
            end
            regex_pkg::FETCH_NEXT:
            begin
                char_next = sel_char;
                // nothing carried over means the string cannot match
                state_next = running ? regex_pkg::EXEC : regex_pkg::DONE_REJECT;
            end
            regex_pkg::DONE_ACCEPT:
            begin
                finish     = 1'b1;
                accept     = 1'b1;
                flush      = 1'b1;
                state_next = regex_pkg::IDLE;
            end
            regex_pkg::DONE_REJECT:
            begin
                finish     = 1'b1;
                flush      = 1'b1;
                state_next = regex_pkg::IDLE;
            end
            default:
                state_next = regex_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state      <= regex_pkg::IDLE;
            char_ptr   <= '0;
            cur_char   <= '0;
            cur_parity <= 1'b0;
        end
        else
        begin
            state      <= state_next;
            char_ptr   <= ptr_next;
            cur_char   <= char_next;
            cur_parity <= parity_next;
        end
    end

endmodule

// File: source/regex_coprocessor.sv
module regex_coprocessor #(
    parameter int MEM_ADDR_WIDTH   = 11,
    parameter int QUEUE_DEPTH_LOG2 = 4
) (
    input  logic                            clk,
    input  logic                            reset,
    output logic                            memory_valid,
    output logic [MEM_ADDR_WIDTH-1:0]       memory_addr,
    input  logic                            memory_ready,
    input  logic [regex_pkg::MEM_WIDTH-1:0] memory_data,
    input  logic                            start,
    input  logic [MEM_ADDR_WIDTH-1:0]       start_addr,
    output logic                            start_ack,
    output logic                            finish,
    output logic                            accept
);

    // memory requests from controller and basic block
    logic                      ctrl_mem_valid;
    logic [MEM_ADDR_WIDTH-1:0] ctrl_mem_addr;
    logic                      ctrl_mem_ready;
    logic                      bb_mem_valid;
    logic [MEM_ADDR_WIDTH-1:0] bb_mem_addr;
    logic                      bb_mem_ready;

    // program counter traffic into and out of the queue
    logic                 inject_valid;
    regex_pkg::pc_entry_t inject_entry;
    logic                 inject_ready;
    logic                 bb_out_valid;
    regex_pkg::pc_entry_t bb_out_entry;
    logic                 bb_out_ready;
    logic                 q_in_valid;
    regex_pkg::pc_entry_t q_in_entry;
    logic                 q_in_ready;
    logic                 q_out_valid;
    regex_pkg::pc_entry_t q_out_entry;
    logic                 q_out_ready;

    // controller to basic block
    logic             go;
    logic             flush;
    regex_pkg::char_t cur_char;
    logic             cur_parity;
    logic             running;
    logic             accepts;
    logic             overflow;
    logic             has_current;

    regex_controller #(
        .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
    ) u_regex_controller (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .start_addr   (start_addr),
        .start_ack    (start_ack),
        .finish       (finish),
        .accept       (accept),
        .mem_valid    (ctrl_mem_valid),
        .mem_addr     (ctrl_mem_addr),
        .mem_ready    (ctrl_mem_ready),
        .mem_data     (memory_data),
        .inject_valid (inject_valid),
        .inject_entry (inject_entry),
        .inject_ready (inject_ready),
        .go           (go),
        .flush        (flush),
        .cur_char     (cur_char),
        .cur_parity   (cur_parity),
        .running      (running),
        .accepts      (accepts),
        .overflow     (overflow)
    );

    basic_block #(
        .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
    ) u_basic_block (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .go          (go),
        .cur_char    (cur_char),
        .cur_parity  (cur_parity),
        .running     (running),
        .accepts     (accepts),
        .overflow    (overflow),
        .queue_valid (q_out_valid),
        .queue_entry (q_out_entry),
        .queue_ready (q_out_ready),
        .out_valid   (bb_out_valid),
        .out_entry   (bb_out_entry),
        .out_ready   (bb_out_ready),
        .mem_valid   (bb_mem_valid),
        .mem_addr    (bb_mem_addr),
        .mem_ready   (bb_mem_ready),
        .mem_data    (memory_data),
        .has_current (has_current)
    );

    pc_queue #(
        .QUEUE_DEPTH_LOG2 (QUEUE_DEPTH_LOG2)
    ) u_pc_queue (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .in_valid    (q_in_valid),
        .in_entry    (q_in_entry),
        .in_ready    (q_in_ready),
        .out_valid   (q_out_valid),
        .out_entry   (q_out_entry),
        .out_ready   (q_out_ready),
        .cur_parity  (cur_parity),
        .has_current (has_current)
    );

    // controller first, its character fetch must not wait on the block
    arbiter_fixed #(
        .payload_t (logic [MEM_ADDR_WIDTH-1:0])
    ) u_mem_arbiter (
        .in_0_valid (ctrl_mem_valid),
        .in_0_data  (ctrl_mem_addr),
        .in_0_ready (ctrl_mem_ready),
        .in_1_valid (bb_mem_valid),
        .in_1_data  (bb_mem_addr),
        .in_1_ready (bb_mem_ready),
        .out_valid  (memory_valid),
        .out_data   (memory_addr),
        .out_ready  (memory_ready)
    );

    // start entry or basic block output into the queue
    arbiter_fixed #(
        .payload_t (regex_pkg::pc_entry_t)
    ) u_inject_arbiter (
        .in_0_valid (inject_valid),
        .in_0_data  (inject_entry),
        .in_0_ready (inject_ready),
        .in_1_valid (bb_out_valid),
        .in_1_data  (bb_out_entry),
        .in_1_ready (bb_out_ready),
        .out_valid  (q_in_valid),
        .out_data   (q_in_entry),
        .out_ready  (q_in_ready)
    );

endmodule

// File: source/regex_pkg.sv
package regex_pkg;

    // character and memory geometry
    localparam int CHAR_WIDTH = 8;
    localparam int MEM_WIDTH  = 16;

    // the instruction operand carries a whole program counter
    localparam int PC_WIDTH = 8;

    typedef logic [CHAR_WIDTH-1:0] char_t;

    // strings end with an all-zero character
    localparam char_t CHAR_TERMINATOR = '0;

    typedef enum logic [2:0] {
        CHAR,
        ANY,
        SPLIT,
        JMP,
        ACCEPT
    } opcode_t;

    // one instruction fills exactly one memory word
    typedef struct packed {
        opcode_t                          opcode;
        logic [MEM_WIDTH-3-PC_WIDTH-1:0]  spare;
        logic [PC_WIDTH-1:0]              operand;
    } instr_t;

    // parity tells which character the program counter belongs to
    typedef struct packed {
        logic [PC_WIDTH-1:0] pc;
        logic                parity;
    } pc_entry_t;

    typedef enum logic [2:0] {
        IDLE,
        FETCH_FIRST,
        FETCH_NEXT,
        EXEC,
        DONE_ACCEPT,
        DONE_REJECT
    } ctrl_state_t;

endpackage

// File: tests/regex_mem_model.sv
module regex_mem_model #(
    parameter int MEM_ADDR_WIDTH = 11
) (
    input  logic                            clk,
    input  logic                            stall_en,
    input  logic                            memory_valid,
    input  logic [MEM_ADDR_WIDTH-1:0]       memory_addr,
    output logic                            memory_ready,
    output logic [regex_pkg::MEM_WIDTH-1:0] memory_data
);

    timeunit 1ns;
    timeprecision 1ps;

    // program from word 0, strings from word 64, written by the testbench
    logic [regex_pkg::MEM_WIDTH-1:0] words [1 << MEM_ADDR_WIDTH];

    int   seed = 32'h4c34_b6c5;
    logic stall_now;

    // one process drives both outputs
    initial
    begin
        memory_ready = 1'b0;
        memory_data <= '0;
        forever
        begin
            @(posedge clk);
            // grant seen at the edge, data shows up one cycle later
            if (memory_valid && memory_ready)
            begin
                memory_data <= words[memory_addr];
            end
            // stall mode as it stood at the edge
            stall_now = stall_en;
            #1;
            // about one cycle in four stalls when enabled
            if (stall_now)
            begin
                memory_ready = (($random(seed) % 4) != 0);
            end
            else
            begin
                memory_ready = 1'b1;
            end
        end
    end

endmodule

// File: tests/tb_regex_coprocessor.sv
module tb_regex_coprocessor;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ADDR_WIDTH  = 11;
    localparam int MEM_WORDS   = 1 << ADDR_WIDTH;
    localparam int STRING_WORD = 64;
    // about twenty runs, each well under two hundred cycles even with stalls
    localparam int CYCLE_LIMIT = 5000;

    logic                            clk = 1'b0;
    logic                            reset;
    logic                            start;
    logic [ADDR_WIDTH-1:0]           start_addr;
    logic                            start_ack;
    logic                            finish;
    logic                            accept;
    logic                            stall_en;
    logic                            memory_valid;
    logic [ADDR_WIDTH-1:0]           memory_addr;
    logic                            memory_ready;
    logic [regex_pkg::MEM_WIDTH-1:0] memory_data;

    int errors       = 0;
    int checks_run   = 0;
    int ack_count    = 0;
    int finish_count = 0;
    int cycle_count  = 0;

    regex_coprocessor #(
        .MEM_ADDR_WIDTH   (ADDR_WIDTH),
        .QUEUE_DEPTH_LOG2 (4)
    ) u_regex_coprocessor (
        .clk          (clk),
        .reset        (reset),
        .memory_valid (memory_valid),
        .memory_addr  (memory_addr),
        .memory_ready (memory_ready),
        .memory_data  (memory_data),
        .start        (start),
        .start_addr   (start_addr),
        .start_ack    (start_ack),
        .finish       (finish),
        .accept       (accept)
    );

    regex_mem_model #(
        .MEM_ADDR_WIDTH (ADDR_WIDTH)
    ) u_mem_model (
        .clk          (clk),
        .stall_en     (stall_en),
        .memory_valid (memory_valid),
        .memory_addr  (memory_addr),
        .memory_ready (memory_ready),
        .memory_data  (memory_data)
    );

    always #10 clk = ~clk;

    // handshake pulses counted mid-cycle where they are settled
    always @(negedge clk)
    begin
        if (start_ack)
        begin
            ack_count = ack_count + 1;
        end
        if (finish)
        begin
            finish_count = finish_count + 1;
        end
    end

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("timeout: no final result after %0d cycles", CYCLE_LIMIT);
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic logic [regex_pkg::MEM_WIDTH-1:0] encode(
        regex_pkg::opcode_t op,
        logic [7:0]         operand
    );
        regex_pkg::instr_t instr;
        instr.opcode  = op;
        instr.spare   = '0;
        instr.operand = operand;
        return instr;
    endfunction

    task automatic put_instr(int addr, regex_pkg::opcode_t op, logic [7:0] operand);
        u_mem_model.words[ADDR_WIDTH'(addr)] = encode(op, operand);
    endtask

    // the low byte of a word holds the even character
    task automatic write_byte(int byte_addr, logic [7:0] value);
        if ((byte_addr % 2) == 0)
        begin
            u_mem_model.words[ADDR_WIDTH'(byte_addr / 2)][7:0] = value;
        end
        else
        begin
            u_mem_model.words[ADDR_WIDTH'(byte_addr / 2)][15:8] = value;
        end
    endtask

    task automatic load_string(string text);
        int base;
        base = STRING_WORD * 2;
        for (int i = 0; i < text.len(); i++)
        begin
            write_byte(base + i, text[i]);
        end
        write_byte(base + text.len(), regex_pkg::CHAR_TERMINATOR);
    endtask

    // odd multiplier keeps every address bit in the pattern
    task automatic fill_memory();
        for (int a = 0; a < MEM_WORDS; a++)
        begin
            u_mem_model.words[ADDR_WIDTH'(a)] = 16'(a * 40503) ^ 16'h3c5a;
        end
    endtask

    task automatic load_literal();
        put_instr(0, regex_pkg::CHAR, "a");
        put_instr(1, regex_pkg::CHAR, "b");
        put_instr(2, regex_pkg::CHAR, "c");
        put_instr(3, regex_pkg::ACCEPT, 8'h00);
    endtask

    // a(b|c). with the two branches joining at the ANY
    task automatic load_alternation();
        put_instr(0, regex_pkg::CHAR, "a");
        put_instr(1, regex_pkg::SPLIT, 8'd4);
        put_instr(2, regex_pkg::CHAR, "b");
        put_instr(3, regex_pkg::JMP, 8'd5);
        put_instr(4, regex_pkg::CHAR, "c");
        put_instr(5, regex_pkg::ANY, 8'h00);
        put_instr(6, regex_pkg::ACCEPT, 8'h00);
    endtask

    // a*b, the split tries the b branch first
    task automatic load_loop();
        put_instr(0, regex_pkg::SPLIT, 8'd3);
        put_instr(1, regex_pkg::CHAR, "a");
        put_instr(2, regex_pkg::JMP, 8'd0);
        put_instr(3, regex_pkg::CHAR, "b");
        put_instr(4, regex_pkg::ACCEPT, 8'h00);
    endtask

    // each split adds one entry and the jump keeps its count, so the queue fills
    task automatic load_runaway();
        put_instr(0, regex_pkg::SPLIT, 8'd0);
        put_instr(1, regex_pkg::JMP, 8'd0);
    endtask

    // bits in order start_ack, finish, accept, memory_valid
    task automatic check_reset_outputs();
        @(negedge clk);
        if ({start_ack, finish, accept, memory_valid} !== 4'b0000)
        begin
            errors = errors + 1;
            $display("Mismatch in reset: expected outputs %b, actual %b",
                     4'b0000, {start_ack, finish, accept, memory_valid});
        end
        @(posedge clk);
        #1;
    endtask

    // one run from start to finish, called right after a rising edge
    task automatic run_case(string name, string text, logic expected);
        int   acks_before;
        int   finishes_before;
        logic got;
        load_string(text);
        acks_before     = ack_count;
        finishes_before = finish_count;
        start = 1'b1;
        @(negedge clk);
        while (!start_ack)
        begin
            @(negedge clk);
        end
        // the start word is requested on the shared port
        if (memory_valid !== 1'b1 || memory_addr !== start_addr)
        begin
            errors = errors + 1;
            $display("Mismatch in %s: expected read at %0d, actual valid %0b at %0d",
                     name, start_addr, memory_valid, memory_addr);
        end
        @(posedge clk);
        #1;
        start = 1'b0;
        @(negedge clk);
        while (!finish)
        begin
            @(negedge clk);
        end
        got = accept;
        checks_run = checks_run + 1;
        if (got !== expected)
        begin
            errors = errors + 1;
            $display("Mismatch in %s: expected accept %0b, actual %0b", name, expected, got);
        end
        @(posedge clk);
        #1;
        if ((ack_count - acks_before) != 1)
        begin
            errors = errors + 1;
            $display("Mismatch in %s: expected 1 start_ack, actual %0d",
                     name, ack_count - acks_before);
        end
        if ((finish_count - finishes_before) != 1)
        begin
            errors = errors + 1;
            $display("Mismatch in %s: expected 1 finish, actual %0d",
                     name, finish_count - finishes_before);
        end
    endtask

    task automatic test_literal();
        load_literal();
        run_case("literal abcd", "abcd", 1'b1);
        run_case("literal abd", "abd", 1'b0);
        // terminator before the last character
        run_case("literal ab", "ab", 1'b0);
    endtask

    task automatic test_alternation();
        load_alternation();
        run_case("alternation abz", "abz", 1'b1);
        run_case("alternation acq", "acq", 1'b1);
        run_case("alternation adz", "adz", 1'b0);
    endtask

    task automatic test_loop();
        load_loop();
        run_case("loop aaab", "aaab", 1'b1);
        run_case("loop b", "b", 1'b1);
        run_case("loop aaa", "aaa", 1'b0);
    endtask

    task automatic test_empty_string();
        load_literal();
        run_case("empty string", "", 1'b0);
    endtask

    // a literal run right after the overflow shows the flush cleared the queue
    task automatic test_overflow();
        load_runaway();
        run_case("overflow", "a", 1'b0);
        load_literal();
        run_case("after overflow", "abcd", 1'b1);
    endtask

    task automatic test_back_to_back();
        stall_en = 1'b1;
        test_literal();
        test_alternation();
        test_loop();
        stall_en = 1'b0;
    endtask

    initial
    begin
        reset      = 1'b1;
        start      = 1'b0;
        start_addr = ADDR_WIDTH'(STRING_WORD);
        stall_en   = 1'b0;
        fill_memory();
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        check_reset_outputs();
        test_literal();
        test_alternation();
        test_loop();
        test_empty_string();
        test_overflow();
        test_back_to_back();

        $display("runs checked: %0d, errors: %0d", checks_run, errors);
        if (errors == 0)
        begin
            $display(">>> PASS");
        end
        else
        begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
